/* bench/fabric_top_tb.sv */
/*
 * testbench for the memory fabric: CPU and DMA stimulus,
 * shadow memory reference model, response checking and timeout
 */

`timescale 1ns/1ps

module fabric_top_tb;

  localparam int N_RAND  = 40;
  localparam int N_CONT  = 30;
  // phase 1 + phase 2 + lane tests + two contention rounds for both masters
  localparam int N_XFER  = 2 + 2 * N_RAND + 6 + 4 * N_CONT;
  localparam int LIMIT   = 20 * N_XFER;

  logic        cpu_clk = 1'b0;
  logic        arst_n;
  logic        cpu_req_valid, cpu_req_ready, cpu_req_write, cpu_rsp_valid, cpu_rsp_ready;
  logic [15:0] cpu_req_addr;
  logic [63:0] cpu_req_wdata, cpu_rsp_rdata;
  logic [7:0]  cpu_req_wstrb;
  logic        dma_req_valid, dma_req_ready, dma_req_write, dma_rsp_valid, dma_rsp_ready;
  logic [15:0] dma_req_addr;
  logic [31:0] dma_req_wdata, dma_rsp_rdata;
  logic [3:0]  dma_req_wstrb;

  logic        bp_en;
  logic        lat_chk;
  int          errors;
  int          timer;

  // reference model state
  logic [63:0] shadow [256];
  logic [7:0]  written [256];
  logic [63:0] cpu_exp_q[$], cpu_msk_q[$], dma_exp_q[$], dma_msk_q[$];

  always #10 cpu_clk = ~cpu_clk;

  fabric_top #(.MEM_WORDS(256)) u_dut (
    .cpu_clk_i (cpu_clk), .arst_n_i (arst_n),
    .cpu_req_valid_i (cpu_req_valid), .cpu_req_ready_o (cpu_req_ready),
    .cpu_req_write_i (cpu_req_write), .cpu_req_addr_i  (cpu_req_addr),
    .cpu_req_wdata_i (cpu_req_wdata), .cpu_req_wstrb_i (cpu_req_wstrb),
    .cpu_rsp_valid_o (cpu_rsp_valid), .cpu_rsp_ready_i (cpu_rsp_ready),
    .cpu_rsp_rdata_o (cpu_rsp_rdata),
    .dma_req_valid_i (dma_req_valid), .dma_req_ready_o (dma_req_ready),
    .dma_req_write_i (dma_req_write), .dma_req_addr_i  (dma_req_addr),
    .dma_req_wdata_i (dma_req_wdata), .dma_req_wstrb_i (dma_req_wstrb),
    .dma_rsp_valid_o (dma_rsp_valid), .dma_rsp_ready_i (dma_rsp_ready),
    .dma_rsp_rdata_o (dma_rsp_rdata)
  );

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected read data, DMA gets the lane picked by address bit 2
  function automatic logic [63:0] ref_read(input logic [15:0] addr, input logic dma);
    logic [63:0] w;
    w = shadow[addr[10:3]];
    if (dma) begin
      w = addr[2] ? {32'h0, w[63:32]} : {32'h0, w[31:0]};
    end
    return w;
  endfunction

  // bit mask of the bytes that were written, same view as ref_read
  function automatic logic [63:0] written_mask(input logic [15:0] addr, input logic dma);
    logic [63:0] m;
    logic [7:0]  wb;
    wb = written[addr[10:3]];
    for (int b = 0; b < 8; b++) begin
      m[8*b +: 8] = {8{wb[b]}};
    end
    if (dma) begin
      m = addr[2] ? {32'h0, m[63:32]} : {32'h0, m[31:0]};
    end
    return m;
  endfunction

  function automatic logic [63:0] merge(input logic [63:0] old, input logic [63:0] nw,
                                        input logic [7:0] strb);
    logic [63:0] r;
    r = old;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) r[8*b +: 8] = nw[8*b +: 8];
    end
    return r;
  endfunction

  task automatic apply_write(input logic [15:0] addr, input logic [63:0] data,
                             input logic [7:0] strb);
    shadow[addr[10:3]]  = merge(shadow[addr[10:3]], data, strb);
    written[addr[10:3]] = written[addr[10:3]] | strb;
  endtask

  // ------------------------------------------------------------
  // monitor and compare
  // ------------------------------------------------------------
  int          cyc;
  int          cpu_acc_cyc, dma_acc_cyc;
  logic        last_acc;
  logic        cpu_hold, dma_hold;
  logic [63:0] cpu_prev, exp_w, msk_w;
  logic [31:0] dma_prev;

  always @(posedge cpu_clk) begin
    cyc <= cyc + 1;
    if (arst_n) begin
      // stable response data under back-pressure
      if (cpu_hold && (!cpu_rsp_valid || cpu_rsp_rdata != cpu_prev)) begin
        $display("MISMATCH cpu_rsp_rdata_o held=%h now=%h", cpu_prev, cpu_rsp_rdata);
        errors++;
      end
      if (dma_hold && (!dma_rsp_valid || dma_rsp_rdata != dma_prev)) begin
        $display("MISMATCH dma_rsp_rdata_o held=%h now=%h", dma_prev, dma_rsp_rdata);
        errors++;
      end
      cpu_hold <= cpu_rsp_valid && !cpu_rsp_ready;
      dma_hold <= dma_rsp_valid && !dma_rsp_ready;
      cpu_prev <= cpu_rsp_rdata;
      dma_prev <= dma_rsp_rdata;

      // responses are taken before the accept of the same edge is recorded
      if (cpu_rsp_valid && cpu_rsp_ready) begin
        if (cpu_exp_q.size() == 0) begin
          $display("response on the CPU port with no request outstanding");
          errors++;
        end else begin
          exp_w = cpu_exp_q.pop_front();
          msk_w = cpu_msk_q.pop_front();
          if ((cpu_rsp_rdata & msk_w) != (exp_w & msk_w)) begin
            $display("MISMATCH cpu_rsp_rdata_o exp=%h got=%h", exp_w & msk_w,
                     cpu_rsp_rdata & msk_w);
            errors++;
          end
        end
        if (lat_chk && cyc != cpu_acc_cyc + 1) begin
          $display("CPU response came %0d cycles after the accept", cyc - cpu_acc_cyc);
          errors++;
        end
      end
      if (dma_rsp_valid && dma_rsp_ready) begin
        if (dma_exp_q.size() == 0) begin
          $display("response on the DMA port with no request outstanding");
          errors++;
        end else begin
          exp_w = dma_exp_q.pop_front();
          msk_w = dma_msk_q.pop_front();
          if (({32'h0, dma_rsp_rdata} & msk_w) != (exp_w & msk_w)) begin
            $display("MISMATCH dma_rsp_rdata_o exp=%h got=%h", exp_w & msk_w,
                     {32'h0, dma_rsp_rdata} & msk_w);
            errors++;
          end
        end
        if (lat_chk && cyc != dma_acc_cyc + 1) begin
          $display("DMA response came %0d cycles after the accept", cyc - dma_acc_cyc);
          errors++;
        end
      end

      // accepts, with the round-robin rule when both wait
      if (cpu_req_valid && cpu_req_ready) begin
        if (dma_req_valid && last_acc == 1'b0) begin
          $display("CPU accepted twice in a row while the DMA was waiting");
          errors++;
        end
        last_acc    <= 1'b0;
        cpu_acc_cyc <= cyc;
        cpu_exp_q.push_back(ref_read(cpu_req_addr, 1'b0));
        cpu_msk_q.push_back(cpu_req_write ? 64'h0 : written_mask(cpu_req_addr, 1'b0));
        if (cpu_req_write) apply_write(cpu_req_addr, cpu_req_wdata, cpu_req_wstrb);
      end
      if (dma_req_valid && dma_req_ready) begin
        if (cpu_req_valid && last_acc == 1'b1) begin
          $display("DMA accepted twice in a row while the CPU was waiting");
          errors++;
        end
        last_acc    <= 1'b1;
        dma_acc_cyc <= cyc;
        dma_exp_q.push_back(ref_read(dma_req_addr, 1'b1));
        dma_msk_q.push_back(dma_req_write ? 64'h0 : written_mask(dma_req_addr, 1'b1));
        if (dma_req_write) begin
          apply_write(dma_req_addr,
                      dma_req_addr[2] ? {dma_req_wdata, 32'h0} : {32'h0, dma_req_wdata},
                      dma_req_addr[2] ? {dma_req_wstrb, 4'h0} : {4'h0, dma_req_wstrb});
        end
      end
    end
  end

  // ------------------------------------------------------------
  // response back-pressure, random stretches per master
  // ------------------------------------------------------------
  logic [31:0] cpu_bp_s = 32'h5dcb;
  logic [31:0] dma_bp_s = 32'h5dcb ^ 32'h1234;
  int          cpu_bp_len, dma_bp_len;

  always @(posedge cpu_clk) begin
    if (!bp_en) begin
      cpu_rsp_ready <= 1'b1;
      dma_rsp_ready <= 1'b1;
    end else begin
      if (cpu_bp_len == 0) begin
        cpu_bp_s       = lcg(cpu_bp_s);
        cpu_rsp_ready <= cpu_bp_s[20];
        cpu_bp_len     = 1 + cpu_bp_s[25:24];
      end else begin
        cpu_bp_len--;
      end
      if (dma_bp_len == 0) begin
        dma_bp_s       = lcg(dma_bp_s);
        dma_rsp_ready <= dma_bp_s[20];
        dma_bp_len     = 1 + dma_bp_s[25:24];
      end else begin
        dma_bp_len--;
      end
    end
  end

  // ------------------------------------------------------------
  // master drivers
  // ------------------------------------------------------------
  task automatic cpu_xfer(input logic wr, input logic [15:0] addr, input logic [63:0] data,
                          input logic [7:0] strb);
    @(posedge cpu_clk);
    cpu_req_valid <= 1'b1;
    cpu_req_write <= wr;
    cpu_req_addr  <= addr;
    cpu_req_wdata <= data;
    cpu_req_wstrb <= strb;
    do @(posedge cpu_clk); while (!cpu_req_ready);
    cpu_req_valid <= 1'b0;
    do @(posedge cpu_clk); while (!(cpu_rsp_valid && cpu_rsp_ready));
  endtask

  task automatic dma_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    @(posedge cpu_clk);
    dma_req_valid <= 1'b1;
    dma_req_write <= wr;
    dma_req_addr  <= addr;
    dma_req_wdata <= data;
    dma_req_wstrb <= strb;
    do @(posedge cpu_clk); while (!dma_req_ready);
    dma_req_valid <= 1'b0;
    do @(posedge cpu_clk); while (!(dma_rsp_valid && dma_rsp_ready));
  endtask

  // requests back to back, the next one raised on the accept of the last
  task automatic cpu_random(input int n, input logic [31:0] seed);
    logic [31:0] s;
    logic [31:0] t;
    s = seed;
    @(posedge cpu_clk);
    for (int i = 0; i < n; i++) begin
      s = lcg(s);
      t = lcg(s);
      cpu_req_valid <= 1'b1;
      cpu_req_write <= s[4];
      cpu_req_addr  <= {6'h0, s[14:8], 3'b000};
      cpu_req_wdata <= {s, t};
      cpu_req_wstrb <= t[27:20];
      do @(posedge cpu_clk); while (!cpu_req_ready);
    end
    cpu_req_valid <= 1'b0;
    // drain the responses still in flight
    do @(posedge cpu_clk); while (cpu_exp_q.size() != 0);
  endtask

  task automatic dma_random(input int n, input logic [31:0] seed);
    logic [31:0] s;
    logic [31:0] t;
    s = seed;
    @(posedge cpu_clk);
    for (int i = 0; i < n; i++) begin
      s = lcg(s);
      t = lcg(s);
      dma_req_valid <= 1'b1;
      dma_req_write <= s[4];
      dma_req_addr  <= {6'h0, s[14:8], s[2], 2'b00};
      dma_req_wdata <= t;
      dma_req_wstrb <= t[23:20];
      do @(posedge cpu_clk); while (!dma_req_ready);
    end
    dma_req_valid <= 1'b0;
    do @(posedge cpu_clk); while (dma_exp_q.size() != 0);
  endtask

  // timeout
  always @(posedge cpu_clk) begin
    timer <= timer + 1;
    if (timer >= LIMIT) begin
      $display("timeout after %0d cycles, transfers did not complete", timer);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    logic [31:0] s;
    arst_n = 1'b0;
    cpu_req_valid = 1'b0;
    cpu_req_write = 1'b0;
    cpu_req_addr = '0;
    cpu_req_wdata = '0;
    cpu_req_wstrb = '0;
    cpu_rsp_ready = 1'b1;
    dma_req_valid = 1'b0;
    dma_req_write = 1'b0;
    dma_req_addr = '0;
    dma_req_wdata = '0;
    dma_req_wstrb = '0;
    dma_rsp_ready = 1'b1;
    bp_en = 1'b0;
    lat_chk = 1'b1;
    errors = 0;
    timer = 0;
    cyc = 0;
    cpu_hold = 1'b0;
    dma_hold = 1'b0;
    last_acc = 1'b1;
    cpu_bp_len = 0;
    dma_bp_len = 0;
    for (int i = 0; i < 256; i++) begin
      written[i] = 8'h0;
      shadow[i]  = 64'h0;
    end
    repeat (4) @(posedge cpu_clk);
    arst_n <= 1'b1;

    // idle fabric after reset
    repeat (2) begin
      @(posedge cpu_clk);
      if (cpu_rsp_valid || dma_rsp_valid) begin
        $display("response valid high after reset with no request");
        errors++;
      end
    end
    cpu_xfer(1'b1, 16'h0008, 64'h0123_4567_89ab_cdef, 8'hff);
    cpu_xfer(1'b0, 16'h0008, 64'h0, 8'h0);

    // random strobes, then read back
    s = 32'h5dcb;
    for (int i = 0; i < N_RAND; i++) begin
      s = lcg(s);
      cpu_xfer(1'b1, 16'(((i % 40) + 8) * 8), {s, ~s}, s[23:16]);
    end
    for (int i = 0; i < N_RAND; i++) begin
      cpu_xfer(1'b0, 16'(((i % 40) + 8) * 8), 64'h0, 8'h0);
    end

    // lane placement in both directions
    dma_xfer(1'b1, 16'h0100, 32'hdead_beef, 4'hf);
    dma_xfer(1'b1, 16'h0104, 32'hcafe_f00d, 4'hf);
    cpu_xfer(1'b0, 16'h0100, 64'h0, 8'h0);
    cpu_xfer(1'b1, 16'h0108, 64'h1122_3344_5566_7788, 8'hff);
    dma_xfer(1'b0, 16'h0108, 32'h0, 4'h0);
    dma_xfer(1'b0, 16'h010c, 32'h0, 4'h0);

    // contention, then contention with back-pressure
    lat_chk <= 1'b0;
    fork
      cpu_random(N_CONT, 32'h5dcb ^ 32'h0a0a);
      dma_random(N_CONT, 32'h5dcb ^ 32'h5050);
    join
    bp_en <= 1'b1;
    fork
      cpu_random(N_CONT, 32'h5dcb ^ 32'h7777);
      dma_random(N_CONT, 32'h5dcb ^ 32'h3c3c);
    join
    bp_en <= 1'b0;
    repeat (4) @(posedge cpu_clk);

    if (cpu_exp_q.size() != 0 || dma_exp_q.size() != 0) begin
      $display("requests left without a response");
      errors++;
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* fabric_top.f */
src/fabric_pkg.sv
src/dma_upsizer.sv
src/bus_arbiter.sv
src/mem_target.sv
src/fabric_top.sv
bench/fabric_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert \
  -f fabric_top.f \
  --top-module fabric_top_tb \
  -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$OBJ/Vfabric_top_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
  exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
  echo "no pass line in $LOG"
  exit 1
fi
exit 0

/* src/bus_arbiter.sv */
/*
 * round-robin arbiter for two masters sharing one memory target,
 * with the response steered back to the master that owns the grant
 */

`timescale 1ns/1ps

module bus_arbiter (
  input  logic                           cpu_clk_i,
  input  logic                           arst_n_i,
  // master 0, CPU
  input  logic                           m0_req_valid_i,
  output logic                           m0_req_ready_o,
  input  logic                           m0_req_write_i,
  input  logic [fabric_pkg::ADDR_W-1:0]  m0_req_addr_i,
  input  logic [fabric_pkg::DATA_W-1:0]  m0_req_wdata_i,
  input  logic [fabric_pkg::STRB_W-1:0]  m0_req_wstrb_i,
  output logic                           m0_rsp_valid_o,
  input  logic                           m0_rsp_ready_i,
  output logic [fabric_pkg::DATA_W-1:0]  m0_rsp_rdata_o,
  // master 1, DMA after the upsizer
  input  logic                           m1_req_valid_i,
  output logic                           m1_req_ready_o,
  input  logic                           m1_req_write_i,
  input  logic [fabric_pkg::ADDR_W-1:0]  m1_req_addr_i,
  input  logic [fabric_pkg::DATA_W-1:0]  m1_req_wdata_i,
  input  logic [fabric_pkg::STRB_W-1:0]  m1_req_wstrb_i,
  output logic                           m1_rsp_valid_o,
  input  logic                           m1_rsp_ready_i,
  output logic [fabric_pkg::DATA_W-1:0]  m1_rsp_rdata_o,
  // target side
  output logic                           s_req_valid_o,
  input  logic                           s_req_ready_i,
  output logic                           s_req_write_o,
  output logic [fabric_pkg::ADDR_W-1:0]  s_req_addr_o,
  output logic [fabric_pkg::DATA_W-1:0]  s_req_wdata_o,
  output logic [fabric_pkg::STRB_W-1:0]  s_req_wstrb_o,
  input  logic                           s_rsp_valid_i,
  output logic                           s_rsp_ready_o,
  input  logic [fabric_pkg::DATA_W-1:0]  s_rsp_rdata_i
);

  logic busy_q;
  logic owner_q;
  logic last_q;
  logic rsp_done;
  logic free;
  logic sel;
  logic accept;

  // ------------------------------------------------------------
  // grant selection
  // ------------------------------------------------------------
  assign rsp_done = s_rsp_valid_i & s_rsp_ready_o;

  // idle, or the owner's response leaves this cycle
  assign free = ~busy_q | rsp_done;

  always_comb begin
    if (!free) begin
      sel = owner_q;
    end else if (m0_req_valid_i && m1_req_valid_i) begin
      // both waiting, the one not served last
      sel = ~last_q;
    end else begin
      sel = m1_req_valid_i;
    end
  end

  // ------------------------------------------------------------
  // request steering
  // ------------------------------------------------------------
  assign s_req_valid_o = free & (sel ? m1_req_valid_i : m0_req_valid_i);
  assign s_req_write_o = sel ? m1_req_write_i : m0_req_write_i;
  assign s_req_addr_o  = sel ? m1_req_addr_i  : m0_req_addr_i;
  assign s_req_wdata_o = sel ? m1_req_wdata_i : m0_req_wdata_i;
  assign s_req_wstrb_o = sel ? m1_req_wstrb_i : m0_req_wstrb_i;

  // ready only toward the selected master
  assign m0_req_ready_o = free & ~sel & s_req_ready_i;
  assign m1_req_ready_o = free &  sel & s_req_ready_i;

  assign accept = s_req_valid_o & s_req_ready_i;

  // ------------------------------------------------------------
  // response routing, back to the owner
  // ------------------------------------------------------------
  assign m0_rsp_valid_o = busy_q & ~owner_q & s_rsp_valid_i;
  assign m1_rsp_valid_o = busy_q &  owner_q & s_rsp_valid_i;
  assign m0_rsp_rdata_o = s_rsp_rdata_i;
  assign m1_rsp_rdata_o = s_rsp_rdata_i;
  assign s_rsp_ready_o  = busy_q & (owner_q ? m1_rsp_ready_i : m0_rsp_ready_i);

  // grant lock from accept to response handshake
  always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
      // master 1 counts as last served, so the CPU wins the first tie
      last_q  <= 1'b1;
    end else if (accept) begin
      busy_q  <= 1'b1;
      owner_q <= sel;
      last_q  <= sel;
    end else if (rsp_done) begin
      busy_q  <= 1'b0;
    end
  end

  a_one_rsp: assert property (@(posedge cpu_clk_i) disable iff (!arst_n_i)
    !(m0_rsp_valid_o && m1_rsp_valid_o));

  // while a transfer is open, it keeps its owner into the next cycle
  a_owner_locked: assert property (@(posedge cpu_clk_i) disable iff (!arst_n_i)
    (busy_q && !rsp_done) |=> (busy_q && $stable(owner_q)));

endmodule

/* src/dma_upsizer.sv */
/*
 * 32-to-64 width converter for the SD DMA master
 */

`timescale 1ns/1ps

module dma_upsizer (
  input  logic                             cpu_clk_i,
  input  logic                             arst_n_i,
  // narrow side, from the DMA master
  input  logic                             n_req_valid_i,
  output logic                             n_req_ready_o,
  input  logic                             n_req_write_i,
  input  logic [fabric_pkg::ADDR_W-1:0]    n_req_addr_i,
  input  logic [fabric_pkg::NARROW_W-1:0]  n_req_wdata_i,
  input  logic [fabric_pkg::NSTRB_W-1:0]   n_req_wstrb_i,
  output logic                             n_rsp_valid_o,
  input  logic                             n_rsp_ready_i,
  output logic [fabric_pkg::NARROW_W-1:0]  n_rsp_rdata_o,
  // wide side, toward the arbiter
  output logic                             w_req_valid_o,
  input  logic                             w_req_ready_i,
  output logic                             w_req_write_o,
  output logic [fabric_pkg::ADDR_W-1:0]    w_req_addr_o,
  output fabric_pkg::bus_word_u            w_req_wdata_o,
  output logic [fabric_pkg::STRB_W-1:0]    w_req_wstrb_o,
  input  logic                             w_rsp_valid_i,
  output logic                             w_rsp_ready_o,
  input  fabric_pkg::bus_word_u            w_rsp_rdata_i
);

  fabric_pkg::lane_sel_t req_lane;
  fabric_pkg::lane_sel_t rsp_lane_q;
  logic                  accept;
  logic                  rsp_done;
  logic                  outstanding_q;

  assign req_lane = fabric_pkg::addr_lane(n_req_addr_i);
  assign accept   = n_req_valid_i & w_req_ready_i;
  assign rsp_done = w_rsp_valid_i & n_rsp_ready_i;

  // ------------------------------------------------------------
  // request path, no added cycles
  // ------------------------------------------------------------
  assign w_req_valid_o = n_req_valid_i;
  assign n_req_ready_o = w_req_ready_i;
  assign w_req_write_o = n_req_write_i;
  assign w_req_addr_o  = n_req_addr_i;
  assign w_req_wdata_o = fabric_pkg::lane_put(n_req_wdata_i, req_lane);
  assign w_req_wstrb_o = fabric_pkg::lane_strb(n_req_wstrb_i, req_lane);

  // lane of the request in flight, used when its response returns
  always_ff @(posedge cpu_clk_i) begin
    if (accept) begin
      rsp_lane_q <= req_lane;
    end
  end

  // ------------------------------------------------------------
  // response path
  // ------------------------------------------------------------
  assign n_rsp_valid_o = w_rsp_valid_i;
  assign w_rsp_ready_o = n_rsp_ready_i;
  assign n_rsp_rdata_o = fabric_pkg::lane_get(w_rsp_rdata_i, rsp_lane_q);

  // a new accept may overlap the previous response leaving
  always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (accept) begin
      outstanding_q <= 1'b1;
    end else if (rsp_done) begin
      outstanding_q <= 1'b0;
    end
  end

  // responses only come back for requests this side issued
  a_rsp_has_req: assert property (@(posedge cpu_clk_i) disable iff (!arst_n_i)
    w_rsp_valid_i |-> outstanding_q);

endmodule

/* src/fabric_pkg.sv */
/*
 * shared bus widths, the 64-bit bus word union and the lane helpers
 */

package fabric_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int ADDR_W   = 16;
  localparam int DATA_W   = 64;
  localparam int NARROW_W = 32;
  localparam int STRB_W   = DATA_W / 8;
  localparam int NSTRB_W  = NARROW_W / 8;

  // one bus word, seen whole or as two 32-bit lanes (lane 0 is the low half)
  typedef union packed {
    logic [DATA_W-1:0]               word;
    logic [1:0][NARROW_W-1:0]        lane;
  } bus_word_u;

  // lane select, taken from byte address bit 2
  typedef logic lane_sel_t;

  // ------------------------------------------------------------
  // lane helpers
  // ------------------------------------------------------------
  function automatic lane_sel_t addr_lane(input logic [ADDR_W-1:0] addr);
    return addr[2];
  endfunction

  // narrow data into its lane, other lane zero
  function automatic bus_word_u lane_put(input logic [NARROW_W-1:0] data, input lane_sel_t lane);
    bus_word_u w;
    w.word = '0;
    w.lane[lane] = data;
    return w;
  endfunction

  function automatic logic [NARROW_W-1:0] lane_get(input bus_word_u w, input lane_sel_t lane);
    return w.lane[lane];
  endfunction

  // 4 strobes moved to the matching half of the 8
  function automatic logic [STRB_W-1:0] lane_strb(input logic [NSTRB_W-1:0] strb,
                                                  input lane_sel_t lane);
    return lane ? {strb, {NSTRB_W{1'b0}}} : {{NSTRB_W{1'b0}}, strb};
  endfunction

endpackage

/* src/fabric_top.sv */
/*
 * memory-side fabric: CPU and SD DMA masters, DMA upsizer,
 * two-master arbiter and the on-chip RAM target
 */

`timescale 1ns/1ps

module fabric_top #(
  parameter int MEM_WORDS = 256
) (
  input  logic                             cpu_clk_i,
  input  logic                             arst_n_i,
  // CPU master, 64 bit
  input  logic                             cpu_req_valid_i,
  output logic                             cpu_req_ready_o,
  input  logic                             cpu_req_write_i,
  input  logic [fabric_pkg::ADDR_W-1:0]    cpu_req_addr_i,
  input  logic [fabric_pkg::DATA_W-1:0]    cpu_req_wdata_i,
  input  logic [fabric_pkg::STRB_W-1:0]    cpu_req_wstrb_i,
  output logic                             cpu_rsp_valid_o,
  input  logic                             cpu_rsp_ready_i,
  output logic [fabric_pkg::DATA_W-1:0]    cpu_rsp_rdata_o,
  // SD DMA master, 32 bit
  input  logic                             dma_req_valid_i,
  output logic                             dma_req_ready_o,
  input  logic                             dma_req_write_i,
  input  logic [fabric_pkg::ADDR_W-1:0]    dma_req_addr_i,
  input  logic [fabric_pkg::NARROW_W-1:0]  dma_req_wdata_i,
  input  logic [fabric_pkg::NSTRB_W-1:0]   dma_req_wstrb_i,
  output logic                             dma_rsp_valid_o,
  input  logic                             dma_rsp_ready_i,
  output logic [fabric_pkg::NARROW_W-1:0]  dma_rsp_rdata_o
);

  // ------------------------------------------------------------
  // upsizer to arbiter port 1
  // ------------------------------------------------------------
  logic                           up_req_valid, up_req_ready, up_req_write;
  logic [fabric_pkg::ADDR_W-1:0]  up_req_addr;
  fabric_pkg::bus_word_u          up_req_wdata, up_rsp_rdata;
  logic [fabric_pkg::STRB_W-1:0]  up_req_wstrb;
  logic                           up_rsp_valid, up_rsp_ready;

  // arbiter to memory
  logic                           mem_req_valid, mem_req_ready, mem_req_write;
  logic [fabric_pkg::ADDR_W-1:0]  mem_req_addr;
  fabric_pkg::bus_word_u          mem_req_wdata, mem_rsp_rdata;
  logic [fabric_pkg::STRB_W-1:0]  mem_req_wstrb;
  logic                           mem_rsp_valid, mem_rsp_ready;

  dma_upsizer u_upsizer (
    .cpu_clk_i, .arst_n_i,
    .n_req_valid_i (dma_req_valid_i), .n_req_ready_o (dma_req_ready_o),
    .n_req_write_i (dma_req_write_i), .n_req_addr_i  (dma_req_addr_i),
    .n_req_wdata_i (dma_req_wdata_i), .n_req_wstrb_i (dma_req_wstrb_i),
    .n_rsp_valid_o (dma_rsp_valid_o), .n_rsp_ready_i (dma_rsp_ready_i),
    .n_rsp_rdata_o (dma_rsp_rdata_o),
    .w_req_valid_o (up_req_valid),    .w_req_ready_i (up_req_ready),
    .w_req_write_o (up_req_write),    .w_req_addr_o  (up_req_addr),
    .w_req_wdata_o (up_req_wdata),    .w_req_wstrb_o (up_req_wstrb),
    .w_rsp_valid_i (up_rsp_valid),    .w_rsp_ready_o (up_rsp_ready),
    .w_rsp_rdata_i (up_rsp_rdata)
  );

  // CPU on port 0, so it wins the first tie after reset
  bus_arbiter u_arbiter (
    .cpu_clk_i, .arst_n_i,
    .m0_req_valid_i (cpu_req_valid_i), .m0_req_ready_o (cpu_req_ready_o),
    .m0_req_write_i (cpu_req_write_i), .m0_req_addr_i  (cpu_req_addr_i),
    .m0_req_wdata_i (cpu_req_wdata_i), .m0_req_wstrb_i (cpu_req_wstrb_i),
    .m0_rsp_valid_o (cpu_rsp_valid_o), .m0_rsp_ready_i (cpu_rsp_ready_i),
    .m0_rsp_rdata_o (cpu_rsp_rdata_o),
    .m1_req_valid_i (up_req_valid),    .m1_req_ready_o (up_req_ready),
    .m1_req_write_i (up_req_write),    .m1_req_addr_i  (up_req_addr),
    .m1_req_wdata_i (up_req_wdata),    .m1_req_wstrb_i (up_req_wstrb),
    .m1_rsp_valid_o (up_rsp_valid),    .m1_rsp_ready_i (up_rsp_ready),
    .m1_rsp_rdata_o (up_rsp_rdata),
    .s_req_valid_o  (mem_req_valid),   .s_req_ready_i  (mem_req_ready),
    .s_req_write_o  (mem_req_write),   .s_req_addr_o   (mem_req_addr),
    .s_req_wdata_o  (mem_req_wdata),   .s_req_wstrb_o  (mem_req_wstrb),
    .s_rsp_valid_i  (mem_rsp_valid),   .s_rsp_ready_o  (mem_rsp_ready),
    .s_rsp_rdata_i  (mem_rsp_rdata)
  );

  mem_target #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .cpu_clk_i, .arst_n_i,
    .req_valid_i (mem_req_valid), .req_ready_o (mem_req_ready),
    .req_write_i (mem_req_write), .req_addr_i  (mem_req_addr),
    .req_wdata_i (mem_req_wdata), .req_wstrb_i (mem_req_wstrb),
    .rsp_valid_o (mem_rsp_valid), .rsp_ready_i (mem_rsp_ready),
    .rsp_rdata_o (mem_rsp_rdata)
  );

endmodule

/* src/mem_target.sv */
/*
 * on-chip RAM target with byte strobes and a registered
 * one-cycle response, one response held at a time
 */

`timescale 1ns/1ps

module mem_target #(
  parameter int MEM_WORDS = 256
) (
  input  logic                           cpu_clk_i,
  input  logic                           arst_n_i,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  logic                           req_write_i,
  input  logic [fabric_pkg::ADDR_W-1:0]  req_addr_i,
  input  fabric_pkg::bus_word_u          req_wdata_i,
  input  logic [fabric_pkg::STRB_W-1:0]  req_wstrb_i,
  output logic                           rsp_valid_o,
  input  logic                           rsp_ready_i,
  output fabric_pkg::bus_word_u          rsp_rdata_o
);

  // word index width, at least one bit
  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [fabric_pkg::DATA_W-1:0] ram [MEM_WORDS];
  logic [IDX_W-1:0]              idx;
  logic                          accept;
  logic                          pend_q;
  fabric_pkg::bus_word_u         rdata_q;

  // byte address bits 2..0 do not reach the RAM
  assign idx = req_addr_i[3 +: IDX_W];

  // ------------------------------------------------------------
  // handshake
  // ------------------------------------------------------------
  // free, or the pending response leaves this cycle
  assign req_ready_o = ~pend_q | rsp_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q <= 1'b0;
    end else if (accept) begin
      pend_q <= 1'b1;
    end else if (rsp_ready_i) begin
      pend_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------
  // per-byte write enable
  always_ff @(posedge cpu_clk_i) begin
    if (accept && req_write_i) begin
      for (int b = 0; b < fabric_pkg::STRB_W; b++) begin
        if (req_wstrb_i[b]) begin
          ram[idx][8*b +: 8] <= req_wdata_i.word[8*b +: 8];
        end
      end
    end
  end

  // read gives the word as it was before a same-cycle write
  always_ff @(posedge cpu_clk_i) begin
    if (accept) begin
      rdata_q.word <= ram[idx];
    end
  end

  assign rsp_valid_o = pend_q;
  assign rsp_rdata_o = rdata_q;

  // held response stays put until taken
  a_rsp_stable: assert property (@(posedge cpu_clk_i) disable iff (!arst_n_i)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_rdata_o.word)));

endmodule
